// ==== build.f ====
tlul_pkg.sv
tl_xbar_periph.sv
tl_gpio.sv
tl_timer.sv
soc_periph_top.sv
soc_periph_asserts.sv
tb_soc_periph.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_soc_periph -f build.f -o sim_tb

./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log || ! grep -q "Simulation finished: PASS" sim.log; then
  echo "run_sim: test failed"
  exit 1
fi
echo "run_sim: test passed"

// ==== tb_soc_periph.sv ====
`default_nettype none

module tb_soc_periph;
  timeunit 1ns;
  timeprecision 1ps;

  // one table row, expected pins only checked when chk is set
  typedef struct packed {
    tlul_pkg::tl_a_op_e          op;
    logic [31:0]                 addr;
    logic [31:0]                 wdata;
    logic [tlul_pkg::GPIO_W-1:0] gin;
    logic [31:0]                 exp_data;
    logic                        exp_err;
    logic                        bp;
    logic                        chk;
    logic [tlul_pkg::GPIO_W-1:0] exp_gpio;
    logic [tlul_pkg::GPIO_W-1:0] exp_oe;
    logic [tlul_pkg::GPIO_W-1:0] exp_intr;
    logic                        exp_tmr;
  } stim_t;

  logic                        clk_i = 1'b0;
  logic                        arst_n_i;
  tlul_pkg::tl_h2d_t           tl_i;
  tlul_pkg::tl_d2h_t           tl_o;
  logic [tlul_pkg::GPIO_W-1:0] gpio_i;
  logic [tlul_pkg::GPIO_W-1:0] gpio_o;
  logic [tlul_pkg::GPIO_W-1:0] gpio_oe_o;
  logic [tlul_pkg::GPIO_W-1:0] intr_gpio_o;
  logic                        intr_timer_o;

  stim_t                       stim_q[$];
  logic [tlul_pkg::GPIO_W-1:0] gin_now = '0;
  logic [31:0]                 lfsr = 32'ha742;
  int                          cycles = 0;
  int                          limit = 0;

  soc_periph_top u_dut (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .tl_i         (tl_i),
    .tl_o         (tl_o),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .gpio_oe_o    (gpio_oe_o),
    .intr_gpio_o  (intr_gpio_o),
    .intr_timer_o (intr_timer_o)
  );

  bind soc_periph_top soc_periph_asserts u_asserts (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .tl_i     (tl_i),
    .tl_o     (tl_o)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      stop_on_error($sformatf("Timeout: the run did not end within %0d cycles", limit));
    end
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic pick_delay(output int n);
    logic [2:0] bits;
    for (int k = 0; k < 3; k++) begin
      lfsr = lfsr_step(lfsr);
      bits[k] = lfsr[0];
    end
    n = int'(bits);
  endtask

  task automatic check_rsp(input tlul_pkg::tl_d2h_t got, input tlul_pkg::tl_d_op_e exp_op,
                           input logic [31:0] exp_data, input logic exp_err,
                           input logic [3:0] exp_src);
    if (got.d_opcode !== exp_op || got.d_data !== exp_data || got.d_error !== exp_err ||
        got.d_source !== exp_src) begin
      stop_on_error($sformatf("Mismatch at %0t ns: op/data/err/src %0d/%h/%b/%h, expected %0d/%h/%b/%h",
                              $time, got.d_opcode, got.d_data, got.d_error, got.d_source,
                              exp_op, exp_data, exp_err, exp_src));
    end
  endtask

  task automatic check_gpio(input logic [tlul_pkg::GPIO_W-1:0] got,
                            input logic [tlul_pkg::GPIO_W-1:0] exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic add_row(input tlul_pkg::tl_a_op_e op, input logic [31:0] addr,
                         input logic [31:0] wdata, input logic [31:0] exp_data,
                         input logic exp_err, input logic bp);
    stim_t s;
    s = '0;
    s.op       = op;
    s.addr     = addr;
    s.wdata    = wdata;
    s.gin      = gin_now;
    s.exp_data = exp_data;
    s.exp_err  = exp_err;
    s.bp       = bp;
    stim_q.push_back(s);
  endtask

  // attach expected pin values to the last row
  task automatic expect_pins(input logic [tlul_pkg::GPIO_W-1:0] pins,
                             input logic [tlul_pkg::GPIO_W-1:0] oe,
                             input logic [tlul_pkg::GPIO_W-1:0] intr, input logic tmr);
    stim_t s;
    int    last;
    last = stim_q.size() - 1;
    s = stim_q[last];
    s.chk      = 1'b1;
    s.exp_gpio = pins;
    s.exp_oe   = oe;
    s.exp_intr = intr;
    s.exp_tmr  = tmr;
    stim_q[last] = s;
  endtask

  task automatic build_table();
    // output data and enable
    add_row(tlul_pkg::PutFullData, 32'h4000_0004, 32'ha5a5_0f0f, 32'h0, 1'b0, 1'b0);
    expect_pins(32'ha5a5_0f0f, 32'h0, 32'h0, 1'b0);
    add_row(tlul_pkg::Get, 32'h4000_0004, 32'h0, 32'ha5a5_0f0f, 1'b0, 1'b1);
    add_row(tlul_pkg::PutFullData, 32'h4000_0008, 32'hffff_00ff, 32'h0, 1'b0, 1'b1);
    expect_pins(32'ha5a5_0f0f, 32'hffff_00ff, 32'h0, 1'b0);
    add_row(tlul_pkg::Get, 32'h4000_0008, 32'h0, 32'hffff_00ff, 1'b0, 1'b0);
    // data_in ignores writes and follows the pins
    gin_now = 32'h1234_5678;
    add_row(tlul_pkg::PutFullData, 32'h4000_0000, 32'hdead_beef, 32'h0, 1'b0, 1'b1);
    add_row(tlul_pkg::Get, 32'h4000_0000, 32'h0, 32'h1234_5678, 1'b0, 1'b1);
    // edges latched but not enabled yet
    add_row(tlul_pkg::Get, 32'h4000_0010, 32'h0, 32'h1234_5678, 1'b0, 1'b0);
    expect_pins(32'ha5a5_0f0f, 32'hffff_00ff, 32'h0, 1'b0);
    add_row(tlul_pkg::PutFullData, 32'h4000_000c, 32'h0000_ff00, 32'h0, 1'b0, 1'b1);
    expect_pins(32'ha5a5_0f0f, 32'hffff_00ff, 32'h0000_5600, 1'b0);
    add_row(tlul_pkg::PutFullData, 32'h4000_0010, 32'h0000_0600, 32'h0, 1'b0, 1'b1);
    expect_pins(32'ha5a5_0f0f, 32'hffff_00ff, 32'h0000_5000, 1'b0);
    // pins held high, cleared bits stay clear
    add_row(tlul_pkg::Get, 32'h4000_0010, 32'h0, 32'h1234_5078, 1'b0, 1'b1);
    gin_now = 32'h1234_ff78;
    add_row(tlul_pkg::Get, 32'h4000_0010, 32'h0, 32'h1234_f978, 1'b0, 1'b0);
    expect_pins(32'ha5a5_0f0f, 32'hffff_00ff, 32'h0000_f900, 1'b0);
    add_row(tlul_pkg::PutFullData, 32'h4000_0010, 32'hffff_ffff, 32'h0, 1'b0, 1'b1);
    expect_pins(32'ha5a5_0f0f, 32'hffff_00ff, 32'h0, 1'b0);
    add_row(tlul_pkg::Get, 32'h4000_0010, 32'h0, 32'h0, 1'b0, 1'b1);
    add_row(tlul_pkg::Get, 32'h4000_000c, 32'h0, 32'h0000_ff00, 1'b0, 1'b0);
    // unmapped addresses and unknown offsets
    add_row(tlul_pkg::Get, 32'h5000_0000, 32'h0, 32'h0, 1'b1, 1'b1);
    add_row(tlul_pkg::PutFullData, 32'h0000_1000, 32'h1111_1111, 32'h0, 1'b1, 1'b0);
    add_row(tlul_pkg::Get, 32'h4000_0020, 32'h0, 32'h0, 1'b1, 1'b1);
    add_row(tlul_pkg::PutFullData, 32'h4001_000c, 32'h2222_2222, 32'h0, 1'b1, 1'b1);
    // timer compare and level interrupt
    add_row(tlul_pkg::PutFullData, 32'h4001_0008, 32'h0000_0050, 32'h0, 1'b0, 1'b1);
    add_row(tlul_pkg::PutFullData, 32'h4001_0004, 32'h0000_0100, 32'h0, 1'b0, 1'b1);
    expect_pins(32'ha5a5_0f0f, 32'hffff_00ff, 32'h0, 1'b0);
    add_row(tlul_pkg::PutFullData, 32'h4001_0000, 32'h0000_0001, 32'h0, 1'b0, 1'b1);
    expect_pins(32'ha5a5_0f0f, 32'hffff_00ff, 32'h0, 1'b1);
    add_row(tlul_pkg::Get, 32'h4001_0000, 32'h0, 32'h0000_0001, 1'b0, 1'b1);
    add_row(tlul_pkg::PutFullData, 32'h4001_0004, 32'h0000_0010, 32'h0, 1'b0, 1'b1);
    expect_pins(32'ha5a5_0f0f, 32'hffff_00ff, 32'h0, 1'b0);
    add_row(tlul_pkg::PutFullData, 32'h4001_0000, 32'h0, 32'h0, 1'b0, 1'b0);
    add_row(tlul_pkg::PutFullData, 32'h4001_0004, 32'h0000_0020, 32'h0, 1'b0, 1'b1);
    expect_pins(32'ha5a5_0f0f, 32'hffff_00ff, 32'h0, 1'b0);
    // stopped counter reads back the same twice
    add_row(tlul_pkg::Get, 32'h4001_0004, 32'h0, 32'h0000_0020, 1'b0, 1'b1);
    add_row(tlul_pkg::Get, 32'h4001_0004, 32'h0, 32'h0000_0020, 1'b0, 1'b1);
    add_row(tlul_pkg::Get, 32'h4001_0008, 32'h0, 32'h0000_0050, 1'b0, 1'b0);
  endtask

  task automatic run_txn(input stim_t s, input logic [3:0] src);
    int                 wait_n;
    tlul_pkg::tl_d2h_t  rsp;
    tlul_pkg::tl_d_op_e exp_op;
    exp_op = (s.op == tlul_pkg::Get) ? tlul_pkg::AccessAckData : tlul_pkg::AccessAck;
    // let the input sampler and edge detect settle
    gpio_i = s.gin;
    repeat (2) @(posedge clk_i);
    #1;
    tl_i.a_valid   = 1'b1;
    tl_i.a_opcode  = s.op;
    tl_i.a_address = s.addr;
    tl_i.a_data    = s.wdata;
    tl_i.a_source  = src;
    @(negedge clk_i);
    while (!tl_o.a_ready) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    tl_i.a_valid = 1'b0;
    check_bit(tl_o.d_valid, 1'b1, "d_valid one cycle after accept");
    check_bit(tl_o.a_ready, 1'b0, "a_ready with response pending");
    wait_n = 0;
    if (s.bp) begin
      pick_delay(wait_n);
    end
    if (wait_n > 0) begin
      repeat (wait_n) @(posedge clk_i);
      #1;
    end
    tl_i.d_ready = 1'b1;
    @(negedge clk_i);
    while (!tl_o.d_valid) @(negedge clk_i);
    rsp = tl_o;
    @(posedge clk_i);
    #1;
    tl_i.d_ready = 1'b0;
    check_rsp(rsp, exp_op, s.exp_data, s.exp_err, src);
    if (s.chk) begin
      check_gpio(gpio_o, s.exp_gpio, "gpio_o");
      check_gpio(gpio_oe_o, s.exp_oe, "gpio_oe_o");
      check_gpio(intr_gpio_o, s.exp_intr, "intr_gpio_o");
      check_bit(intr_timer_o, s.exp_tmr, "intr_timer_o");
    end
  endtask

  initial begin
    arst_n_i = 1'b0;
    tl_i     = '0;
    gpio_i   = '0;
    build_table();
    limit = 16 + stim_q.size() * 12 + 100;
    repeat (16) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    check_bit(tl_o.d_valid, 1'b0, "d_valid after reset");
    check_bit(tl_o.a_ready, 1'b1, "a_ready after reset");
    check_gpio(gpio_o, '0, "gpio_o after reset");
    check_gpio(gpio_oe_o, '0, "gpio_oe_o after reset");
    check_gpio(intr_gpio_o, '0, "intr_gpio_o after reset");
    check_bit(intr_timer_o, 1'b0, "intr_timer_o after reset");
    foreach (stim_q[i]) begin
      run_txn(stim_q[i], i[3:0]);
    end
    if (u_dut.u_asserts.fail_cnt != 0) begin
      stop_on_error($sformatf("bound assertions failed %0d times", u_dut.u_asserts.fail_cnt));
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== soc_periph_asserts.sv ====
`default_nettype none

module soc_periph_asserts (
  input logic              clk_i,
  input logic              arst_n_i,
  input tlul_pkg::tl_h2d_t tl_i,
  input tlul_pkg::tl_d2h_t tl_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;

  // held response keeps its fields until taken
  rsp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (tl_o.d_valid && !tl_i.d_ready) |=> (tl_o.d_valid &&
      $stable({tl_o.d_opcode, tl_o.d_data, tl_o.d_source, tl_o.d_error})))
    else begin
      $error("response changed before d_ready");
      fail_cnt++;
    end

  // accepted request answered on the next cycle with a_ready low
  ready_low: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (tl_i.a_valid && tl_o.a_ready) |=> (tl_o.d_valid && !tl_o.a_ready))
    else begin
      $error("no pending response with a_ready low one cycle after acceptance");
      fail_cnt++;
    end

  valid_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(tl_o.d_valid))
    else begin
      $error("d_valid unknown after reset");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== soc_periph_top.sv ====
`default_nettype none

module soc_periph_top (
  input  logic                        clk_i,
  input  logic                        arst_n_i,

  // host port
  input  tlul_pkg::tl_h2d_t           tl_i,
  output tlul_pkg::tl_d2h_t           tl_o,

  // gpio pins
  input  logic [tlul_pkg::GPIO_W-1:0] gpio_i,
  output logic [tlul_pkg::GPIO_W-1:0] gpio_o,
  output logic [tlul_pkg::GPIO_W-1:0] gpio_oe_o,

  // interrupts
  output logic [tlul_pkg::GPIO_W-1:0] intr_gpio_o,
  output logic                        intr_timer_o
);

  tlul_pkg::tl_h2d_t xbar_to_gpio;
  tlul_pkg::tl_d2h_t gpio_to_xbar;
  tlul_pkg::tl_h2d_t xbar_to_timer;
  tlul_pkg::tl_d2h_t timer_to_xbar;

  // peripheral crossbar
  tl_xbar_periph u_xbar (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .tl_h_i     (tl_i),
    .tl_h_o     (tl_o),
    .tl_gpio_o  (xbar_to_gpio),
    .tl_gpio_i  (gpio_to_xbar),
    .tl_timer_o (xbar_to_timer),
    .tl_timer_i (timer_to_xbar)
  );

  tl_gpio u_gpio (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .tl_i        (xbar_to_gpio),
    .tl_o        (gpio_to_xbar),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_oe_o   (gpio_oe_o),
    .intr_gpio_o (intr_gpio_o)
  );

  tl_timer u_timer (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .tl_i         (xbar_to_timer),
    .tl_o         (timer_to_xbar),
    .intr_timer_o (intr_timer_o)
  );

endmodule

`default_nettype wire

// ==== tl_timer.sv ====
`default_nettype none

module tl_timer (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  tlul_pkg::tl_h2d_t tl_i,
  output tlul_pkg::tl_d2h_t tl_o,
  output logic              intr_timer_o
);

  logic [31:0]                 count_q;
  logic [31:0]                 cmp_q;
  logic                        en_q;
  logic [tlul_pkg::OFFS_W-1:0] offset;
  logic [31:0]                 rd_data;
  logic                        reg_err;
  logic                        is_get;
  logic                        is_put;
  logic                        bad;
  logic                        accept;
  logic                        wr_en;
  logic                        rsp_valid_q;
  logic                        rsp_err_q;
  tlul_pkg::tl_d_op_e          rsp_op_q;
  logic [31:0]                 rsp_data_q;
  logic [3:0]                  rsp_src_q;

  assign offset = tl_i.a_address[tlul_pkg::OFFS_W-1:0];
  assign is_get = (tl_i.a_opcode == tlul_pkg::Get);
  assign is_put = (tl_i.a_opcode == tlul_pkg::PutFullData);
  assign bad    = reg_err || !(is_get || is_put);
  assign accept = tl_i.a_valid && !rsp_valid_q;
  assign wr_en  = accept && is_put && !reg_err;

  always_comb begin
    rd_data = '0;
    reg_err = 1'b0;
    case (offset)
      tlul_pkg::TIMER_CTRL:  rd_data = {31'b0, en_q};
      tlul_pkg::TIMER_COUNT: rd_data = count_q;
      tlul_pkg::TIMER_CMP:   rd_data = cmp_q;
      default:               reg_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q    <= 1'b0;
      count_q <= '0;
      cmp_q   <= '0;
    end else begin
      if (wr_en && offset == tlul_pkg::TIMER_CTRL) begin
        en_q <= tl_i.a_data[0];
      end
      if (wr_en && offset == tlul_pkg::TIMER_CMP) begin
        cmp_q <= tl_i.a_data;
      end
      // bus write wins over the increment
      if (wr_en && offset == tlul_pkg::TIMER_COUNT) begin
        count_q <= tl_i.a_data;
      end else if (en_q) begin
        count_q <= count_q + 32'd1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (tl_i.d_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_op_q   <= is_get ? tlul_pkg::AccessAckData : tlul_pkg::AccessAck;
      rsp_data_q <= (is_get && !bad) ? rd_data : '0;
      rsp_src_q  <= tl_i.a_source;
      rsp_err_q  <= bad;
    end
  end

  assign tl_o = '{
    d_valid:  rsp_valid_q,
    d_opcode: rsp_op_q,
    d_data:   rsp_data_q,
    d_source: rsp_src_q,
    d_error:  rsp_err_q,
    a_ready:  ~rsp_valid_q
  };

  // level interrupt, only while counting
  assign intr_timer_o = en_q && (count_q >= cmp_q);

endmodule

`default_nettype wire

// ==== tl_gpio.sv ====
`default_nettype none

module tl_gpio (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  tlul_pkg::tl_h2d_t           tl_i,
  output tlul_pkg::tl_d2h_t           tl_o,
  input  logic [tlul_pkg::GPIO_W-1:0] gpio_i,
  output logic [tlul_pkg::GPIO_W-1:0] gpio_o,
  output logic [tlul_pkg::GPIO_W-1:0] gpio_oe_o,
  output logic [tlul_pkg::GPIO_W-1:0] intr_gpio_o
);

  logic [tlul_pkg::GPIO_W-1:0] data_out_q;
  logic [tlul_pkg::GPIO_W-1:0] oe_q;
  logic [tlul_pkg::GPIO_W-1:0] intr_en_q;
  logic [tlul_pkg::GPIO_W-1:0] intr_state_q;
  logic [tlul_pkg::GPIO_W-1:0] in_q;
  logic [tlul_pkg::GPIO_W-1:0] in_prev_q;
  logic [tlul_pkg::GPIO_W-1:0] rise;
  logic [tlul_pkg::GPIO_W-1:0] clr;
  logic [tlul_pkg::OFFS_W-1:0] offset;
  logic [31:0]                 rd_data;
  logic                        reg_err;
  logic                        is_get;
  logic                        is_put;
  logic                        bad;
  logic                        accept;
  logic                        wr_en;
  logic                        rsp_valid_q;
  logic                        rsp_err_q;
  tlul_pkg::tl_d_op_e          rsp_op_q;
  logic [31:0]                 rsp_data_q;
  logic [3:0]                  rsp_src_q;

  assign offset = tl_i.a_address[tlul_pkg::OFFS_W-1:0];
  assign is_get = (tl_i.a_opcode == tlul_pkg::Get);
  assign is_put = (tl_i.a_opcode == tlul_pkg::PutFullData);
  assign bad    = reg_err || !(is_get || is_put);
  assign accept = tl_i.a_valid && !rsp_valid_q;
  assign wr_en  = accept && is_put && !reg_err;

  always_comb begin
    rd_data = '0;
    reg_err = 1'b0;
    case (offset)
      tlul_pkg::GPIO_DATA_IN:    rd_data = in_q;
      tlul_pkg::GPIO_DATA_OUT:   rd_data = data_out_q;
      tlul_pkg::GPIO_OE:         rd_data = oe_q;
      tlul_pkg::GPIO_INTR_EN:    rd_data = intr_en_q;
      tlul_pkg::GPIO_INTR_STATE: rd_data = intr_state_q;
      default:                   reg_err = 1'b1;
    endcase
  end

  // DATA_IN writes land here and change nothing
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_out_q <= '0;
      oe_q       <= '0;
      intr_en_q  <= '0;
    end else if (wr_en) begin
      case (offset)
        tlul_pkg::GPIO_DATA_OUT: data_out_q <= tl_i.a_data;
        tlul_pkg::GPIO_OE:       oe_q       <= tl_i.a_data;
        tlul_pkg::GPIO_INTR_EN:  intr_en_q  <= tl_i.a_data;
        default: ;
      endcase
    end
  end

  // sampled input and rising edge detect
  assign rise = in_q & ~in_prev_q;
  assign clr  = (wr_en && offset == tlul_pkg::GPIO_INTR_STATE) ? tl_i.a_data : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_q         <= '0;
      in_prev_q    <= '0;
      intr_state_q <= '0;
    end else begin
      in_q         <= gpio_i;
      in_prev_q    <= in_q;
      // new edge beats a clear in the same cycle
      intr_state_q <= (intr_state_q & ~clr) | rise;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (tl_i.d_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_op_q   <= is_get ? tlul_pkg::AccessAckData : tlul_pkg::AccessAck;
      rsp_data_q <= (is_get && !bad) ? rd_data : '0;
      rsp_src_q  <= tl_i.a_source;
      rsp_err_q  <= bad;
    end
  end

  assign tl_o = '{
    d_valid:  rsp_valid_q,
    d_opcode: rsp_op_q,
    d_data:   rsp_data_q,
    d_source: rsp_src_q,
    d_error:  rsp_err_q,
    a_ready:  ~rsp_valid_q
  };

  assign gpio_o      = data_out_q;
  assign gpio_oe_o   = oe_q;
  assign intr_gpio_o = intr_state_q & intr_en_q;

endmodule

`default_nettype wire

// ==== tl_xbar_periph.sv ====
`default_nettype none

module tl_xbar_periph (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  tlul_pkg::tl_h2d_t tl_h_i,
  output tlul_pkg::tl_d2h_t tl_h_o,
  output tlul_pkg::tl_h2d_t tl_gpio_o,
  input  tlul_pkg::tl_d2h_t tl_gpio_i,
  output tlul_pkg::tl_h2d_t tl_timer_o,
  input  tlul_pkg::tl_d2h_t tl_timer_i
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_DEV,
    ERR_RSP
  } state_e;

  state_e            state_q;
  state_e            state_d;
  logic              hit_gpio;
  logic              hit_timer;
  logic              sel_gpio_q;
  logic              a_ready_idle;
  logic              accept;
  logic              err_get_q;
  logic [3:0]        err_src_q;
  tlul_pkg::tl_d2h_t dev_rsp;

  assign hit_gpio  = (tl_h_i.a_address & tlul_pkg::ADDR_MASK_DEV) == tlul_pkg::ADDR_GPIO;
  assign hit_timer = (tl_h_i.a_address & tlul_pkg::ADDR_MASK_DEV) == tlul_pkg::ADDR_TIMER;

  // unmapped requests are always taken, the error comes from here
  assign a_ready_idle = hit_gpio  ? tl_gpio_i.a_ready :
                        hit_timer ? tl_timer_i.a_ready : 1'b1;
  assign accept = tl_h_i.a_valid && a_ready_idle && (state_q == IDLE);

  // only the addressed device sees a_valid
  always_comb begin
    tl_gpio_o          = tl_h_i;
    tl_gpio_o.a_valid  = tl_h_i.a_valid && hit_gpio && (state_q == IDLE);
    tl_gpio_o.d_ready  = tl_h_i.d_ready && sel_gpio_q && (state_q == WAIT_DEV);
    tl_timer_o         = tl_h_i;
    tl_timer_o.a_valid = tl_h_i.a_valid && hit_timer && (state_q == IDLE);
    tl_timer_o.d_ready = tl_h_i.d_ready && !sel_gpio_q && (state_q == WAIT_DEV);
  end

  assign dev_rsp = sel_gpio_q ? tl_gpio_i : tl_timer_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = (hit_gpio || hit_timer) ? WAIT_DEV : ERR_RSP;
        end
      end
      WAIT_DEV: begin
        if (dev_rsp.d_valid && tl_h_i.d_ready) begin
          state_d = IDLE;
        end
      end
      ERR_RSP: begin
        if (tl_h_i.d_ready) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= IDLE;
      sel_gpio_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        sel_gpio_q <= hit_gpio;
      end
    end
  end

  // kept for the locally built error response
  always_ff @(posedge clk_i) begin
    if (accept) begin
      err_get_q <= (tl_h_i.a_opcode == tlul_pkg::Get);
      err_src_q <= tl_h_i.a_source;
    end
  end

  always_comb begin
    tl_h_o = '0;
    case (state_q)
      WAIT_DEV: begin
        tl_h_o         = dev_rsp;
        tl_h_o.a_ready = 1'b0;
      end
      ERR_RSP: begin
        tl_h_o.d_valid  = 1'b1;
        tl_h_o.d_opcode = err_get_q ? tlul_pkg::AccessAckData : tlul_pkg::AccessAck;
        tl_h_o.d_source = err_src_q;
        tl_h_o.d_error  = 1'b1;
      end
      default: tl_h_o.a_ready = a_ready_idle;
    endcase
  end

endmodule

`default_nettype wire

// ==== tlul_pkg.sv ====
`default_nettype none

package tlul_pkg;

  // request opcodes, TL-UL encoding
  typedef enum logic [2:0] {
    PutFullData = 3'h0,
    Get         = 3'h4
  } tl_a_op_e;

  // response opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // host to device, A channel plus d_ready
  typedef struct packed {
    logic        a_valid;
    tl_a_op_e    a_opcode;
    logic [31:0] a_address;
    logic [31:0] a_data;
    logic [3:0]  a_source;
    logic        d_ready;
  } tl_h2d_t;

  // device to host, D channel plus a_ready
  typedef struct packed {
    logic        d_valid;
    tl_d_op_e    d_opcode;
    logic [31:0] d_data;
    logic [3:0]  d_source;
    logic        d_error;
    logic        a_ready;
  } tl_d2h_t;

  // address map, upper half selects the device
  localparam logic [31:0] ADDR_MASK_DEV = 32'hffff_0000;
  localparam logic [31:0] ADDR_GPIO     = 32'h4000_0000;
  localparam logic [31:0] ADDR_TIMER    = 32'h4001_0000;

  // register offset width inside a device window
  localparam int OFFS_W = 16;

  // gpio registers
  localparam logic [OFFS_W-1:0] GPIO_DATA_IN    = 16'h0000;
  localparam logic [OFFS_W-1:0] GPIO_DATA_OUT   = 16'h0004;
  localparam logic [OFFS_W-1:0] GPIO_OE         = 16'h0008;
  localparam logic [OFFS_W-1:0] GPIO_INTR_EN    = 16'h000c;
  // write 1 to clear
  localparam logic [OFFS_W-1:0] GPIO_INTR_STATE = 16'h0010;

  // timer registers
  localparam logic [OFFS_W-1:0] TIMER_CTRL  = 16'h0000;
  localparam logic [OFFS_W-1:0] TIMER_COUNT = 16'h0004;
  localparam logic [OFFS_W-1:0] TIMER_CMP   = 16'h0008;

  localparam int GPIO_W = 32;

endpackage

`default_nettype wire
